/* list.f */
rtl/rs_pkg.sv
rtl/rs_entry_if.sv
rtl/rs_entry.sv
rtl/rs_select.sv
rtl/rs_top.sv
tests/rs_props.sv
tests/rs_tb.sv

/* Makefile */
SIM  := obj_dir/rs_sim
SRCS := $(wildcard rtl/*.sv tests/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module rs_tb -f list.f -o rs_sim

# pass only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf obj_dir

/* tests/rs_tb.sv */
`timescale 1ns/10ps

module rs_tb import rs_pkg::*; ();

    logic             clock;
    logic             rst_n;
    logic             squash;
    logic             disp_valid;
    logic [OP_W-1:0]  disp_op;
    logic [TAG_W-1:0] disp_dest;
    logic             disp_rs1_ready;
    logic [TAG_W-1:0] disp_rs1_tag;
    logic [XLEN-1:0]  disp_rs1_value;
    logic             disp_rs2_ready;
    logic [TAG_W-1:0] disp_rs2_tag;
    logic [XLEN-1:0]  disp_rs2_value;
    logic             cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    logic [XLEN-1:0]  cdb_value;
    logic             issue_valid;
    logic [OP_W-1:0]  issue_op;
    logic [TAG_W-1:0] issue_dest;
    logic [XLEN-1:0]  issue_rs1_value;
    logic [XLEN-1:0]  issue_rs2_value;
    logic             rs_full;

    integer           seed = 35;
    int               cycle_count = 0;

    rs_top u_rs_top (
        .clock           (clock),
        .rst_n           (rst_n),
        .squash          (squash),
        .disp_valid      (disp_valid),
        .disp_op         (disp_op),
        .disp_dest       (disp_dest),
        .disp_rs1_ready  (disp_rs1_ready),
        .disp_rs1_tag    (disp_rs1_tag),
        .disp_rs1_value  (disp_rs1_value),
        .disp_rs2_ready  (disp_rs2_ready),
        .disp_rs2_tag    (disp_rs2_tag),
        .disp_rs2_value  (disp_rs2_value),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .issue_valid     (issue_valid),
        .issue_op        (issue_op),
        .issue_dest      (issue_dest),
        .issue_rs1_value (issue_rs1_value),
        .issue_rs2_value (issue_rs2_value),
        .rs_full         (rs_full)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;                // 8 ns period
    end

    // whole run is well under 400 cycles
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 400) begin
            $display("timeout: the tests did not finish within 400 cycles");
            $display("Test FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check(input string name, input logic [XLEN-1:0] expected,
                         input logic [XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "first wrong value ends the run");
        end
    endtask

    // inputs go back to idle each cycle unless a driver below overrides them
    task automatic next_cycle();
        @(posedge clock);
        disp_valid <= 1'b0;
        cdb_valid  <= 1'b0;
        squash     <= 1'b0;
    endtask

    task automatic settle();
        @(negedge clock);                         // outputs stable mid-cycle
    endtask

    task automatic drive_dispatch(input logic [OP_W-1:0] op, input logic [TAG_W-1:0] dest,
                                  input logic r1_rdy, input logic [TAG_W-1:0] r1_tag,
                                  input logic [XLEN-1:0] r1_val,
                                  input logic r2_rdy, input logic [TAG_W-1:0] r2_tag,
                                  input logic [XLEN-1:0] r2_val);
        disp_valid     <= 1'b1;
        disp_op        <= op;
        disp_dest      <= dest;
        disp_rs1_ready <= r1_rdy;
        disp_rs1_tag   <= r1_tag;
        disp_rs1_value <= r1_val;
        disp_rs2_ready <= r2_rdy;
        disp_rs2_tag   <= r2_tag;
        disp_rs2_value <= r2_val;
    endtask

    task automatic drive_cdb(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] value);
        cdb_valid <= 1'b1;
        cdb_tag   <= tag;
        cdb_value <= value;
    endtask

    task automatic issue_matches(input string name, input logic [OP_W-1:0] op,
                                 input logic [TAG_W-1:0] dest,
                                 input logic [XLEN-1:0] v1, input logic [XLEN-1:0] v2);
        check(name, 1, XLEN'(issue_valid));
        check(name, XLEN'(op), XLEN'(issue_op));
        check(name, XLEN'(dest), XLEN'(issue_dest));
        check(name, v1, issue_rs1_value);
        check(name, v2, issue_rs2_value);
    endtask

    task automatic station_quiet(input string name);
        check(name, '0, XLEN'(issue_valid));
    endtask

    task automatic ready_dispatch();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = $random(seed);
        b = $random(seed);
        next_cycle();
        drive_dispatch(4'h3, 4'h1, 1'b1, 4'h0, a, 1'b1, 4'h0, b);
        settle();
        station_quiet("ready_dispatch");          // loads at the edge ending this cycle
        next_cycle();
        settle();
        issue_matches("ready_dispatch", 4'h3, 4'h1, a, b);
        next_cycle();
        settle();
        station_quiet("ready_dispatch");          // cleared after issue
    endtask

    task automatic cdb_wakeup();
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] v;
        b = $random(seed);
        v = $random(seed);
        next_cycle();
        drive_dispatch(4'h5, 4'h2, 1'b0, 4'h5, '0, 1'b1, 4'h0, b);
        settle();
        repeat (2) begin
            next_cycle();
            settle();
            station_quiet("cdb_wakeup");          // still waiting on tag 5
        end
        next_cycle();
        drive_cdb(4'h5, v);
        settle();
        issue_matches("cdb_wakeup", 4'h5, 4'h2, v, b);   // forwarded in the broadcast cycle
        next_cycle();
        settle();
        station_quiet("cdb_wakeup");
    endtask

    task automatic dispatch_capture();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] v;
        a = $random(seed);
        v = $random(seed);
        next_cycle();
        drive_dispatch(4'h6, 4'h4, 1'b1, 4'h0, a, 1'b0, 4'h9, '0);
        drive_cdb(4'h9, v);                       // producer finishes as we dispatch
        settle();
        station_quiet("dispatch_capture");
        next_cycle();
        settle();
        issue_matches("dispatch_capture", 4'h6, 4'h4, a, v);
        next_cycle();
        settle();
        station_quiet("dispatch_capture");
    endtask

    task automatic full_and_order();
        logic [XLEN-1:0] v;
        logic [XLEN-1:0] b [RS_SIZE];
        int              i;
        v = $random(seed);
        for (i = 0; i < RS_SIZE; i++) begin
            b[i] = $random(seed);
            next_cycle();
            drive_dispatch(OP_W'(i), TAG_W'(i + 8), 1'b0, 4'h7, '0, 1'b1, 4'h0, b[i]);
            settle();
        end
        next_cycle();
        drive_dispatch(4'hf, 4'hf, 1'b0, 4'h7, '0, 1'b1, 4'h0, '1);   // must be dropped
        settle();
        check("full_and_order", 1, XLEN'(rs_full));
        station_quiet("full_and_order");
        next_cycle();
        drive_cdb(4'h7, v);                       // one broadcast wakes every entry
        settle();
        for (i = 0; i < RS_SIZE; i++) begin
            if (i > 0) begin
                next_cycle();
                settle();
            end
            issue_matches("full_and_order", OP_W'(i), TAG_W'(i + 8), v, b[i]);
        end
        next_cycle();
        settle();
        station_quiet("full_and_order");          // dropped one never shows up
        check("full_and_order", '0, XLEN'(rs_full));
    endtask

    task automatic squash_flush();
        next_cycle();
        drive_dispatch(4'h1, 4'h3, 1'b0, 4'h3, '0, 1'b1, 4'h0, '0);
        settle();
        next_cycle();
        drive_dispatch(4'h2, 4'h4, 1'b1, 4'h0, '0, 1'b0, 4'h4, '0);
        settle();
        next_cycle();
        squash <= 1'b1;
        settle();
        for (int t = 3; t <= 4; t++) begin
            next_cycle();
            drive_cdb(TAG_W'(t), $random(seed));  // producers of the flushed entries
            settle();
            station_quiet("squash_flush");
            check("squash_flush", '0, XLEN'(rs_full));
        end
    endtask

    // scoreboard model of the entry array, lowest index for both dispatch and issue
    task automatic random_mix();
        logic             m_busy [RS_SIZE];
        logic [OP_W-1:0]  m_op   [RS_SIZE];
        logic [TAG_W-1:0] m_dest [RS_SIZE];
        logic             m_rdy  [RS_SIZE][2];
        logic [TAG_W-1:0] m_tag  [RS_SIZE][2];
        logic [XLEN-1:0]  m_val  [RS_SIZE][2];
        logic             d_valid;
        logic [OP_W-1:0]  d_op;
        logic [TAG_W-1:0] d_dest;
        logic             d_rdy [2];
        logic [TAG_W-1:0] d_tag [2];
        logic [XLEN-1:0]  d_val [2];
        logic             c_valid;
        logic [TAG_W-1:0] c_tag;
        logic [XLEN-1:0]  c_val;
        logic             hit [2];
        logic [XLEN-1:0]  e_val [2];
        logic             e_valid;
        logic             e_full;
        logic [31:0]      r;
        int               i;
        int               k;
        int               sel;
        int               free;
        int               n_disp;
        int               n_busy;
        int               cyc;
        for (i = 0; i < RS_SIZE; i++) begin
            m_busy[i] = 1'b0;
        end
        n_disp = 0;
        n_busy = 0;
        cyc    = 0;
        while (n_disp < 20 || n_busy > 0) begin
            r = $random(seed);
            d_valid  = (n_disp < 20) && (r[1:0] != 2'b00);
            c_valid  = (n_disp >= 20) || r[2];    // drain phase broadcasts every cycle
            c_tag    = (n_disp >= 20) ? TAG_W'(cyc % 4) : TAG_W'(r[4:3]);
            d_op     = r[5 +: OP_W];
            d_dest   = r[12 +: TAG_W];
            d_rdy[0] = r[20];
            d_rdy[1] = r[21];
            d_tag[0] = TAG_W'(r[23:22]);          // small tag pool so waits resolve
            d_tag[1] = TAG_W'(r[25:24]);
            d_val[0] = $random(seed);
            d_val[1] = $random(seed);
            c_val    = $random(seed);
            next_cycle();
            if (d_valid) begin
                drive_dispatch(d_op, d_dest, d_rdy[0], d_tag[0], d_val[0],
                               d_rdy[1], d_tag[1], d_val[1]);
            end
            if (c_valid) begin
                drive_cdb(c_tag, c_val);
            end
            settle();
            // predict, scanning down so the lowest index wins
            e_valid = 1'b0;
            e_full  = 1'b1;
            sel     = 0;
            free    = 0;
            for (i = RS_SIZE - 1; i >= 0; i--) begin
                for (k = 0; k < 2; k++) begin
                    hit[k] = m_busy[i] && c_valid && !m_rdy[i][k] && (m_tag[i][k] == c_tag);
                end
                if (m_busy[i] && (m_rdy[i][0] || hit[0]) && (m_rdy[i][1] || hit[1])) begin
                    e_valid = 1'b1;
                    sel     = i;
                    for (k = 0; k < 2; k++) begin
                        e_val[k] = hit[k] ? c_val : m_val[i][k];
                    end
                end
                if (!m_busy[i]) begin
                    e_full = 1'b0;
                    free   = i;
                end
            end
            check("random_mix", XLEN'(e_valid), XLEN'(issue_valid));
            check("random_mix", XLEN'(e_full), XLEN'(rs_full));
            if (e_valid) begin
                issue_matches("random_mix", m_op[sel], m_dest[sel], e_val[0], e_val[1]);
            end
            // advance the model to the state after the edge
            for (i = 0; i < RS_SIZE; i++) begin
                for (k = 0; k < 2; k++) begin
                    if (m_busy[i] && c_valid && !m_rdy[i][k] && (m_tag[i][k] == c_tag)) begin
                        m_rdy[i][k] = 1'b1;
                        m_val[i][k] = c_val;
                    end
                end
            end
            if (e_valid) begin
                m_busy[sel] = 1'b0;
            end
            if (d_valid && !e_full) begin
                m_busy[free] = 1'b1;
                m_op[free]   = d_op;
                m_dest[free] = d_dest;
                for (k = 0; k < 2; k++) begin
                    hit[k]          = c_valid && !d_rdy[k] && (d_tag[k] == c_tag);
                    m_rdy[free][k]  = d_rdy[k] || hit[k];
                    m_tag[free][k]  = d_tag[k];
                    m_val[free][k]  = hit[k] ? c_val : d_val[k];
                end
                n_disp++;
            end
            n_busy = 0;
            for (i = 0; i < RS_SIZE; i++) begin
                n_busy += int'(m_busy[i]);
            end
            cyc++;
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        squash         = 1'b0;
        disp_valid     = 1'b0;
        disp_op        = '0;
        disp_dest      = '0;
        disp_rs1_ready = 1'b0;
        disp_rs1_tag   = '0;
        disp_rs1_value = '0;
        disp_rs2_ready = 1'b0;
        disp_rs2_tag   = '0;
        disp_rs2_value = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_value      = '0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        settle();
        check("reset", '0, XLEN'(issue_valid));
        check("reset", '0, XLEN'(rs_full));
        ready_dispatch();
        cdb_wakeup();
        dispatch_capture();
        full_and_order();
        squash_flush();
        random_mix();
        $display("Test OK");
        $finish;
    end

endmodule

/* tests/rs_props.sv */
`timescale 1ns/10ps

module rs_props import rs_pkg::*; (
    input logic               clock,
    input logic               rst_n,
    input logic               squash,
    input logic               issue_valid,
    input logic [RS_SIZE-1:0] busy_vec,      // entry busy flags from the select logic
    input logic [RS_SIZE-1:0] wr_vec         // one-hot entry load strobes
);

    // an issuing entry must be holding an instruction
    issue_needs_busy: assert property (@(posedge clock) disable iff (!rst_n)
        issue_valid |-> (|busy_vec))
        else $error("issue_valid high while no entry is busy");

    // a load only lands on an idle entry
    // a full station has no idle entry, so it takes nothing
    no_load_into_busy: assert property (@(posedge clock) disable iff (!rst_n)
        (|wr_vec) |-> ((wr_vec & busy_vec) == '0))
        else $error("entry loaded while it or the whole station was busy");

    // flush leaves nothing to issue in the following cycle
    quiet_after_squash: assert property (@(posedge clock) disable iff (!rst_n)
        squash |=> !issue_valid)
        else $error("issue_valid high in the cycle after squash");

endmodule

// squash lives at the top, the sampling clock and vectors inside the select logic
bind rs_top rs_props u_rs_props (
    .clock       (u_rs_select.clock),
    .rst_n       (u_rs_select.rst_n),
    .squash      (squash),
    .issue_valid (issue_valid),
    .busy_vec    (u_rs_select.busy_vec),
    .wr_vec      (u_rs_select.wr_vec)
);

/* rtl/rs_top.sv */
`timescale 1ns/10ps

module rs_top import rs_pkg::*; (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             squash,
    // dispatch from the front end
    input  logic             disp_valid,
    input  logic [OP_W-1:0]  disp_op,
    input  logic [TAG_W-1:0] disp_dest,
    input  logic             disp_rs1_ready,
    input  logic [TAG_W-1:0] disp_rs1_tag,
    input  logic [XLEN-1:0]  disp_rs1_value,
    input  logic             disp_rs2_ready,
    input  logic [TAG_W-1:0] disp_rs2_tag,
    input  logic [XLEN-1:0]  disp_rs2_value,
    // common data bus
    input  logic             cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  logic [XLEN-1:0]  cdb_value,
    // issue to the execution unit
    output logic             issue_valid,
    output logic [OP_W-1:0]  issue_op,
    output logic [TAG_W-1:0] issue_dest,
    output logic [XLEN-1:0]  issue_rs1_value,
    output logic [XLEN-1:0]  issue_rs2_value,
    output logic             rs_full       // front end stalls dispatch on this
);

    // one bundle per entry
    rs_entry_if ent_if [RS_SIZE] ();

    rs_select u_rs_select (
        .clock           (clock),
        .rst_n           (rst_n),
        .disp_valid      (disp_valid),
        .disp_op         (disp_op),
        .disp_dest       (disp_dest),
        .disp_rs1_ready  (disp_rs1_ready),
        .disp_rs1_tag    (disp_rs1_tag),
        .disp_rs1_value  (disp_rs1_value),
        .disp_rs2_ready  (disp_rs2_ready),
        .disp_rs2_tag    (disp_rs2_tag),
        .disp_rs2_value  (disp_rs2_value),
        .entries         (ent_if),
        .issue_valid     (issue_valid),
        .issue_op        (issue_op),
        .issue_dest      (issue_dest),
        .issue_rs1_value (issue_rs1_value),
        .issue_rs2_value (issue_rs2_value),
        .rs_full         (rs_full)
    );

    // entries all watch the same cdb
    for (genvar g = 0; g < RS_SIZE; g++) begin : g_entry
        rs_entry u_rs_entry (
            .clock     (clock),
            .rst_n     (rst_n),
            .squash    (squash),
            .cdb_valid (cdb_valid),
            .cdb_tag   (cdb_tag),
            .cdb_value (cdb_value),
            .port      (ent_if[g].entry)
        );
    end

endmodule

/* rtl/rs_select.sv */
`timescale 1ns/10ps

module rs_select import rs_pkg::*; (
    input  logic             clock,           // sampling clock for bound checks
    input  logic             rst_n,
    input  logic             disp_valid,
    input  logic [OP_W-1:0]  disp_op,
    input  logic [TAG_W-1:0] disp_dest,
    input  logic             disp_rs1_ready,
    input  logic [TAG_W-1:0] disp_rs1_tag,
    input  logic [XLEN-1:0]  disp_rs1_value,
    input  logic             disp_rs2_ready,
    input  logic [TAG_W-1:0] disp_rs2_tag,
    input  logic [XLEN-1:0]  disp_rs2_value,
    rs_entry_if.station      entries [RS_SIZE],
    output logic             issue_valid,
    output logic [OP_W-1:0]  issue_op,
    output logic [TAG_W-1:0] issue_dest,
    output logic [XLEN-1:0]  issue_rs1_value,
    output logic [XLEN-1:0]  issue_rs2_value,
    output logic             rs_full
);

    // flattened entry status, interface arrays need constant indices
    logic [RS_SIZE-1:0]  busy_vec;
    logic [RS_SIZE-1:0]  ready_vec;
    logic [OP_W-1:0]     op_arr   [RS_SIZE];
    logic [TAG_W-1:0]    dest_arr [RS_SIZE];
    logic [XLEN-1:0]     rs1_arr  [RS_SIZE];
    logic [XLEN-1:0]     rs2_arr  [RS_SIZE];

    logic [RS_IDX_W-1:0] free_idx;            // lowest idle entry
    logic [RS_IDX_W-1:0] issue_idx;           // lowest ready entry
    logic                disp_fire;           // dispatch accepted this cycle
    logic [RS_SIZE-1:0]  wr_vec;
    logic [RS_SIZE-1:0]  clr_vec;

    for (genvar g = 0; g < RS_SIZE; g++) begin : g_port
        // status in
        assign busy_vec[g]  = entries[g].busy;
        assign ready_vec[g] = entries[g].ready;
        assign op_arr[g]    = entries[g].op;
        assign dest_arr[g]  = entries[g].dest;
        assign rs1_arr[g]   = entries[g].rs1_value;
        assign rs2_arr[g]   = entries[g].rs2_value;

        // strobes out, one-hot
        assign wr_vec[g]  = disp_fire && (free_idx == RS_IDX_W'(g));
        assign clr_vec[g] = issue_valid && (issue_idx == RS_IDX_W'(g));
        assign entries[g].wr_en = wr_vec[g];
        assign entries[g].clear = clr_vec[g];

        // dispatch fields broadcast to all entries
        assign entries[g].disp_op        = disp_op;
        assign entries[g].disp_dest      = disp_dest;
        assign entries[g].disp_rs1_ready = disp_rs1_ready;
        assign entries[g].disp_rs1_tag   = disp_rs1_tag;
        assign entries[g].disp_rs1_value = disp_rs1_value;
        assign entries[g].disp_rs2_ready = disp_rs2_ready;
        assign entries[g].disp_rs2_tag   = disp_rs2_tag;
        assign entries[g].disp_rs2_value = disp_rs2_value;
    end

    assign rs_full   = &busy_vec;
    assign disp_fire = disp_valid && !rs_full;    // strobe while full is dropped

    // priority encoders, scan downward so the lowest index lands last
    always_comb begin
        free_idx = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!busy_vec[i]) begin
                free_idx = RS_IDX_W'(i);
            end
        end
    end

    always_comb begin
        issue_idx = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                issue_idx = RS_IDX_W'(i);
            end
        end
    end

    // issue mux, ready implies busy so a written entry is never picked
    assign issue_valid     = |ready_vec;
    assign issue_op        = op_arr[issue_idx];
    assign issue_dest      = dest_arr[issue_idx];
    assign issue_rs1_value = rs1_arr[issue_idx];
    assign issue_rs2_value = rs2_arr[issue_idx];

endmodule

/* rtl/rs_entry.sv */
`timescale 1ns/10ps

module rs_entry import rs_pkg::*; (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             squash,      // rob flush, drops the entry at the edge
    input  logic             cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  logic [XLEN-1:0]  cdb_value,
    rs_entry_if.entry        port
);

    // control state
    logic             busy_q;
    logic             rs1_rdy_q;          // rs1 value held in the entry
    logic             rs2_rdy_q;

    // held instruction
    logic [OP_W-1:0]  op_q;
    logic [TAG_W-1:0] dest_q;
    logic [TAG_W-1:0] rs1_tag_q;          // producer tag while waiting
    logic [TAG_W-1:0] rs2_tag_q;
    logic [XLEN-1:0]  rs1_val_q;
    logic [XLEN-1:0]  rs2_val_q;

    // cdb matches against waiting operands of the held instruction
    logic             rs1_hit;
    logic             rs2_hit;

    // cdb matches against the operands being dispatched right now
    logic             disp_rs1_hit;
    logic             disp_rs2_hit;

    logic             ready_c;

    // only a busy entry with a still-waiting operand can wake up
    assign rs1_hit = busy_q && cdb_valid && !rs1_rdy_q && (cdb_tag == rs1_tag_q);
    assign rs2_hit = busy_q && cdb_valid && !rs2_rdy_q && (cdb_tag == rs2_tag_q);

    // producer finishing in the dispatch cycle itself
    // the map table has not seen it yet, so catch it here or it is lost
    assign disp_rs1_hit = cdb_valid && !port.disp_rs1_ready &&
                          (cdb_tag == port.disp_rs1_tag);
    assign disp_rs2_hit = cdb_valid && !port.disp_rs2_ready &&
                          (cdb_tag == port.disp_rs2_tag);

    // busy and operand flags
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            rs1_rdy_q <= 1'b0;
            rs2_rdy_q <= 1'b0;
        end else if (squash) begin
            busy_q    <= 1'b0;                // flags are don't care once idle
        end else if (port.wr_en) begin
            busy_q    <= 1'b1;
            rs1_rdy_q <= port.disp_rs1_ready || disp_rs1_hit;
            rs2_rdy_q <= port.disp_rs2_ready || disp_rs2_hit;
        end else begin
            if (port.clear) begin
                busy_q <= 1'b0;               // issued this cycle
            end
            if (rs1_hit) begin
                rs1_rdy_q <= 1'b1;
            end
            if (rs2_hit) begin
                rs2_rdy_q <= 1'b1;
            end
        end
    end

    // payload, qualified by busy so no reset
    always_ff @(posedge clock) begin
        if (port.wr_en) begin
            op_q      <= port.disp_op;
            dest_q    <= port.disp_dest;
            rs1_tag_q <= port.disp_rs1_tag;
            rs2_tag_q <= port.disp_rs2_tag;
            // cdb value wins over the dispatched value on a same-cycle match
            rs1_val_q <= disp_rs1_hit ? cdb_value : port.disp_rs1_value;
            rs2_val_q <= disp_rs2_hit ? cdb_value : port.disp_rs2_value;
        end else begin
            if (rs1_hit) begin
                rs1_val_q <= cdb_value;       // capture broadcast
            end
            if (rs2_hit) begin
                rs2_val_q <= cdb_value;
            end
        end
    end

    // ready, four ways to get there
    always_comb begin
        ready_c = 1'b0;
        if (busy_q) begin
            case ({rs1_rdy_q, rs2_rdy_q})
                2'b11:   ready_c = 1'b1;                 // both held
                2'b10:   ready_c = rs2_hit;              // rs2 from cdb now
                2'b01:   ready_c = rs1_hit;              // rs1 from cdb now
                default: ready_c = rs1_hit && rs2_hit;   // both wait on one tag
            endcase
        end
    end

    assign port.ready = ready_c;
    assign port.busy  = busy_q;
    assign port.op    = op_q;
    assign port.dest  = dest_q;

    // forward the bus so a wakeup can issue in its own cycle
    assign port.rs1_value = rs1_hit ? cdb_value : rs1_val_q;
    assign port.rs2_value = rs2_hit ? cdb_value : rs2_val_q;

endmodule

/* rtl/rs_entry_if.sv */
`timescale 1ns/10ps

interface rs_entry_if import rs_pkg::*; ();

    // load and clear strobes from the station, never high together
    logic             wr_en;
    logic             clear;

    // dispatch fields, copied to every entry, only the written one latches them
    logic [OP_W-1:0]  disp_op;
    logic [TAG_W-1:0] disp_dest;        // rob slot of this instruction
    logic             disp_rs1_ready;
    logic [TAG_W-1:0] disp_rs1_tag;
    logic [XLEN-1:0]  disp_rs1_value;
    logic             disp_rs2_ready;
    logic [TAG_W-1:0] disp_rs2_tag;
    logic [XLEN-1:0]  disp_rs2_value;

    // entry status and issue fields
    logic             busy;
    logic             ready;            // includes same-cycle cdb wakeup
    logic [OP_W-1:0]  op;
    logic [TAG_W-1:0] dest;
    logic [XLEN-1:0]  rs1_value;        // already forwarded from the cdb
    logic [XLEN-1:0]  rs2_value;

    modport station (
        output wr_en, clear, disp_op, disp_dest,
        output disp_rs1_ready, disp_rs1_tag, disp_rs1_value,
        output disp_rs2_ready, disp_rs2_tag, disp_rs2_value,
        input  busy, ready, op, dest, rs1_value, rs2_value
    );

    modport entry (
        input  wr_en, clear, disp_op, disp_dest,
        input  disp_rs1_ready, disp_rs1_tag, disp_rs1_value,
        input  disp_rs2_ready, disp_rs2_tag, disp_rs2_value,
        output busy, ready, op, dest, rs1_value, rs2_value
    );

endinterface

/* rtl/rs_pkg.sv */
package rs_pkg;

    // datapath word, rv32
    localparam int XLEN = 32;

    // rob tag width
    // 16 rob entries, so a tag is the rob slot number
    localparam int TAG_W = 4;

    // alu function code carried through to the functional unit
    localparam int OP_W = 4;

    // station depth
    // rs_select and rs_top follow this for any power of two >= 2
    localparam int RS_SIZE = 4;

    // entry index width, derived from the depth
    localparam int RS_IDX_W = $clog2(RS_SIZE);

    // operand source convention used throughout
    //   ready = 1 : value field holds the operand
    //   ready = 0 : tag field names the rob entry that will produce it
    //
    // issue picks the lowest-index ready entry
    // dispatch fills the lowest-index idle entry
    //
    // a cdb broadcast matching a waiting tag is forwarded straight to
    // the issue outputs in the same cycle, and latched at the edge

endpackage
